// ==== Makefile ====
# Verilator simulation of the cipher machine

.PHONY: run clean

run: obj_dir/Vcipher_machine_tb
	@out="$$(./obj_dir/Vcipher_machine_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "ALL CHECKS PASSED"

obj_dir/Vcipher_machine_tb: src.f $(wildcard src/*.sv sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module cipher_machine_tb -Mdir obj_dir

clean:
	rm -rf obj_dir

// ==== sim/cipher_machine_props.sv ====
// Bound into cipher_machine and reaches loader credit and FIFO fill by instance name; off in reset
`timescale 1ns/100ps

module cipher_machine_props #(
	parameter int depth = 4
) (
	input logic clock,
	input logic resetn,
	input link_pkg::credit_t credit,
	input logic token_valid,
	input link_pkg::credit_t count,
	input logic done
);

	credit_cap: assert property (@(posedge clock) disable iff (!resetn) credit <= depth)
		else $error("loader credit above buffer depth");

	// A credit stands for a free buffer entry
	token_needs_credit: assert property (@(posedge clock) disable iff (!resetn)
		token_valid |-> count < depth)
		else $error("token issued into a full buffer");

	fill_cap: assert property (@(posedge clock) disable iff (!resetn) count <= depth)
		else $error("FIFO fill above depth");

	done_single: assert property (@(posedge clock) disable iff (!resetn) done |=> !done)
		else $error("done longer than one cycle");

endmodule

bind cipher_machine cipher_machine_props #(.depth(depth)) props_i (
	.clock(clock), .resetn(resetn),
	.credit(loader_i.credit), .token_valid(token_valid),
	.count(fifo_i.count), .done(done)
);

// ==== sim/cipher_machine_tb.sv ====
// Depth 4 only; eight table rows plus a carry-over run and a sixth-load run, done expected 7 cycles after go
`timescale 1ns/100ps

module cipher_machine_tb;

	localparam int period = 100;
	localparam int drive_delay = 10;   // Inputs change this long after the rising edge
	localparam int num_rows = 8;
	localparam int num_runs = num_rows + 2; // Table, carry-over, sixth load
	localparam int done_latency = 7;    // Cycles from go to done

	// One stimulus row, keys packed like a message
	typedef struct packed {
		cipher_pkg::message_t letters;
		cipher_pkg::message_t keys;
		logic [1:0] mode;               // Raw code so 2'd3 fits
		logic dec;
		cipher_pkg::message_t expected; // Worked out by hand
	} row_t;

	logic clock;
	logic resetn;
	logic letter_valid;
	cipher_pkg::letter_t letter_in;
	logic key_valid;
	cipher_pkg::shift_t key_in;
	logic go;
	cipher_pkg::method_e method;
	logic decode;
	logic busy;
	logic done;
	cipher_pkg::message_t result;

	row_t rows [num_rows];
	cipher_pkg::letter_t carried [cipher_pkg::msg_len]; // Letters loaded mid run
	int errors = 0;
	int tests = 0;

	cipher_machine #(.depth(4)) cipher_machine_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// Watchdog allows about 40 cycles per run plus reset
	initial
	begin
		#((num_runs * 40 + 8) * period);
		$display("Timeout: the runs did not finish in the expected time");
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic cipher_pkg::message_t make_message(input int a, b, c, d, e);
		return {cipher_pkg::letter_t'(a), cipher_pkg::letter_t'(b), cipher_pkg::letter_t'(c),
			cipher_pkg::letter_t'(d), cipher_pkg::letter_t'(e)};
	endfunction

	task automatic log_error(input string text);
		$display("%s", text);
		errors++;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#drive_delay;
	endtask

	// Five letters and five keys, one slot per cycle
	task automatic load_message(input cipher_pkg::message_t letters,
		input cipher_pkg::message_t keys);
		for (int i = 0; i < cipher_pkg::msg_len; i++)
		begin
			letter_valid = 1'b1;
			key_valid = 1'b1;
			letter_in = letters[24 - 5 * i -: 5]; // Slot 0 at the top
			key_in = keys[24 - 5 * i -: 5];
			next_cycle();
		end
		letter_valid = 1'b0;
		key_valid = 1'b0;
	endtask

	// go, wait for done, then check value, latency and quiet afterwards
	task automatic run_and_check(input logic [1:0] mode, input logic dec,
		input cipher_pkg::message_t expected);
		int cycles;
		int errors_before;
		int gap;
		errors_before = errors;
		tests++;
		method = cipher_pkg::method_e'(mode);
		decode = dec;
		go = 1'b1;
		letter_valid = 1'b1; // Written on the go edge, after the snapshot
		letter_in = cipher_pkg::letter_t'($urandom);
		carried[0] = letter_in;
		cycles = 0;
		while (!done && cycles < 3 * done_latency)
		begin
			next_cycle();
			cycles++;
			if (cycles == 1)
			begin
				assert (busy) else log_error($sformatf("MISMATCH at %0t: busy expected 1 got %b",
					$time, busy));
			end
			go = (cycles == 3); // Extra request while busy
			letter_valid = (cycles < cipher_pkg::msg_len);
			if (cycles < cipher_pkg::msg_len)
			begin
				letter_in = cipher_pkg::letter_t'($urandom); // Any code, read back next run
				carried[cycles] = letter_in;
			end
		end
		go = 1'b0;
		letter_valid = 1'b0;
		assert (done) else log_error($sformatf("Test %0d: done never came", tests));
		assert (!done || cycles == done_latency) else log_error($sformatf(
			"MISMATCH at %0t: done latency expected %0d got %0d", $time, done_latency, cycles));
		assert (busy) else log_error($sformatf("MISMATCH at %0t: busy at done expected 1 got %b",
			$time, busy));
		assert (result == expected) else log_error($sformatf(
			"MISMATCH at %0t: result expected %h got %h", $time, expected, result));
		next_cycle();
		assert (!done) else log_error($sformatf("MISMATCH at %0t: done expected 0 got %b",
			$time, done));
		assert (!busy) else log_error($sformatf("MISMATCH at %0t: busy expected 0 got %b",
			$time, busy));
		gap = $urandom_range(1, 4);
		repeat (gap)
		begin
			next_cycle();
			assert (!done) else log_error($sformatf(
				"MISMATCH at %0t: done after run expected 0 got %b", $time, done));
		end
		assert (result == expected) else log_error($sformatf(
			"MISMATCH at %0t: result after run expected %h got %h", $time, expected, result));
		$display("Test %0d: %s, done after %0d cycles", tests,
			(errors == errors_before) ? "pass" : "fail", cycles);
	endtask

	initial
	begin
		void'($urandom(32'h436ceb8f));
		resetn = 1'b0;
		letter_valid = 1'b0;
		letter_in = '0;
		key_valid = 1'b0;
		key_in = '0;
		go = 1'b0;
		method = cipher_pkg::method_plain;
		decode = 1'b0;
		// letters, keys, method, decode, expected
		rows[0] = '{make_message(24, 25, 26, 1, 2), make_message(3, 0, 0, 0, 0), 2'd1, 1'b0,
			make_message(1, 2, 3, 4, 5)};      // Caesar wraps past z
		rows[1] = '{make_message(1, 2, 3, 4, 5), make_message(3, 9, 9, 9, 9), 2'd1, 1'b1,
			make_message(24, 25, 26, 1, 2)};   // Caesar decode
		rows[2] = '{make_message(8, 5, 12, 12, 15), make_message(1, 2, 3, 30, 25), 2'd2, 1'b0,
			make_message(9, 7, 15, 16, 14)};   // Key 30 acts as 4
		rows[3] = '{make_message(9, 7, 15, 16, 14), make_message(1, 2, 3, 30, 25), 2'd2, 1'b1,
			make_message(8, 5, 12, 12, 15)};
		rows[4] = '{make_message(0, 27, 3, 31, 26), make_message(5, 6, 7, 8, 9), 2'd0, 1'b0,
			make_message(0, 27, 3, 31, 26)};   // Plain copies
		rows[5] = '{make_message(1, 2, 0, 27, 26), make_message(4, 4, 4, 4, 4), 2'd3, 1'b1,
			make_message(1, 2, 0, 27, 26)};    // Spare code
		rows[6] = '{make_message(0, 27, 1, 13, 20), make_message(26, 27, 31, 13, 0), 2'd2, 1'b0,
			make_message(0, 27, 6, 26, 20)};
		rows[7] = '{make_message(0, 27, 1, 3, 26), make_message(29, 0, 0, 0, 0), 2'd1, 1'b1,
			make_message(0, 27, 24, 26, 23)};  // Wraps before a
		repeat (4) @(posedge clock);
		#drive_delay;
		resetn = 1'b1;
		tests++;
		assert (!busy) else log_error($sformatf("MISMATCH at %0t: busy expected 0 got %b",
			$time, busy));
		assert (!done) else log_error($sformatf("MISMATCH at %0t: done expected 0 got %b",
			$time, done));
		assert (result == '0) else log_error($sformatf(
			"MISMATCH at %0t: result expected 0 got %h", $time, result));
		$display("Test %0d: %s, reset values", tests, (errors == 0) ? "pass" : "fail");
		for (int i = 0; i < num_rows; i++)
		begin
			load_message(rows[i].letters, rows[i].keys);
			run_and_check(rows[i].mode, rows[i].dec, rows[i].expected);
		end
		// No reload so the last run's mid-run letters come out
		run_and_check(2'd0, 1'b0, {carried[0], carried[1], carried[2], carried[3], carried[4]});
		load_message(make_message(1, 2, 3, 4, 5), make_message(0, 0, 0, 0, 0));
		letter_valid = 1'b1;
		letter_in = cipher_pkg::letter_t'(20); // Sixth load lands in slot 0
		next_cycle();
		letter_valid = 1'b0;
		run_and_check(2'd0, 1'b0, make_message(20, 2, 3, 4, 5));
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
src/cipher_pkg.sv
src/link_pkg.sv
src/message_loader.sv
src/token_fifo.sv
src/shift_cipher_unit.sv
src/cipher_machine.sv
sim/cipher_machine_props.sv
sim/cipher_machine_tb.sv

// ==== src/cipher_machine.sv ====
// Top level; depth sets both the buffer size and the loader's credit, legal from 2 to 15
`timescale 1ns/100ps

module cipher_machine #(
	parameter int depth = 4
) (
	input  logic clock,
	input  logic resetn,
	input  logic letter_valid,
	input  cipher_pkg::letter_t letter_in,
	input  logic key_valid,
	input  cipher_pkg::shift_t key_in,
	input  logic go,
	input  cipher_pkg::method_e method,
	input  logic decode,
	output logic busy,
	output logic done,
	output cipher_pkg::message_t result
);

	logic token_valid;
	link_pkg::letter_token_t token;
	link_pkg::letter_token_t head;
	logic not_empty;
	logic pop;
	logic credit_return;

	// Producer
	message_loader #(.depth(depth)) loader_i (
		.clock(clock), .resetn(resetn),
		.letter_valid(letter_valid), .key_valid(key_valid),
		.letter_in(letter_in), .key_in(key_in),
		.go(go), .decode(decode), .method(method),
		.credit_return(credit_return), .done(done),
		.token_valid(token_valid), .token(token), .busy(busy)
	);

	// Token buffer
	token_fifo #(.depth(depth)) fifo_i (
		.clock(clock), .resetn(resetn),
		.token_valid(token_valid), .token(token), .pop(pop),
		.head(head), .not_empty(not_empty), .credit_return(credit_return)
	);

	// Consumer
	shift_cipher_unit shift_i (
		.clock(clock), .resetn(resetn),
		.head(head), .not_empty(not_empty),
		.pop(pop), .result(result), .done(done)
	);

endmodule

// ==== src/cipher_pkg.sv ====
// Letter codes 1..26 only; other codes are carried through untouched, message length is fixed at five
package cipher_pkg;

	// One letter code, a is 1 and z is 26
	typedef logic [4:0] letter_t;

	// Key or shift amount, used mod 26
	typedef logic [4:0] shift_t;

	// Slot index into a message
	typedef logic [2:0] slot_t;

	localparam int msg_len = 5; // Letters per message

	localparam letter_t letter_first = 5'd1;  // a
	localparam letter_t letter_last  = 5'd26; // z
	localparam shift_t alphabet_size = 5'd26;

	// Whole message, slot 0 in the top bits
	typedef struct packed {
		letter_t l0;
		letter_t l1;
		letter_t l2;
		letter_t l3;
		letter_t l4;
	} message_t;

	// Cipher method select
	// Code 2'd3 has no name and runs as plain
	typedef enum logic [1:0] {
		method_plain    = 2'd0,
		method_caesar   = 2'd1,
		method_vigenere = 2'd2
	} method_e;

endpackage

// ==== src/link_pkg.sv ====
// Token and credit types for the loader-to-consumer link; credit_t limits the buffer depth to 15
package link_pkg;

	// One letter in flight between loader and shift unit
	typedef struct packed {
		cipher_pkg::letter_t letter; // Source letter code
		cipher_pkg::shift_t shift;   // Already reduced mod 26
		logic backward;              // Decode direction
		cipher_pkg::slot_t slot;     // Result position
	} letter_token_t;

	// Credit count, also used for buffer fill
	typedef logic [3:0] credit_t;

endpackage

// ==== src/message_loader.sv ====
// Issues a token only with credit; loads during a run go to the slots, never to the running snapshot
`timescale 1ns/100ps

module message_loader #(
	parameter int depth = 4
) (
	input  logic clock,
	input  logic resetn,
	input  logic letter_valid,
	input  logic key_valid,
	input  cipher_pkg::letter_t letter_in,
	input  cipher_pkg::shift_t key_in,
	input  logic go,
	input  logic decode,
	input  cipher_pkg::method_e method,
	input  logic credit_return,
	input  logic done,
	output logic token_valid,
	output link_pkg::letter_token_t token,
	output logic busy
);

	typedef enum logic [1:0] {
		load_idle,
		load_send,
		load_wait_done
	} load_state_e;

	localparam cipher_pkg::slot_t last_slot = cipher_pkg::slot_t'(cipher_pkg::msg_len - 1);

	load_state_e state;
	cipher_pkg::letter_t letters [cipher_pkg::msg_len]; // User letter slots
	cipher_pkg::shift_t keys [cipher_pkg::msg_len];     // User key slots
	cipher_pkg::slot_t letter_idx;
	cipher_pkg::slot_t key_idx;

	// Run snapshot taken on go
	cipher_pkg::letter_t snap_letters [cipher_pkg::msg_len];
	cipher_pkg::shift_t snap_keys [cipher_pkg::msg_len];
	cipher_pkg::method_e snap_method;
	logic snap_decode;

	cipher_pkg::slot_t send_idx; // Next letter to issue
	link_pkg::credit_t credit;
	cipher_pkg::shift_t raw_shift;

	assign busy = (state != load_idle);
	assign token_valid = (state == load_send) && (credit != '0); // Stall at zero credit

	// Shift choice per method, spare code runs as plain
	always_comb
	begin
		case (snap_method)
			cipher_pkg::method_caesar:   raw_shift = snap_keys[0];
			cipher_pkg::method_vigenere: raw_shift = snap_keys[send_idx];
			default:                     raw_shift = '0;
		endcase
		token.letter = snap_letters[send_idx];
		token.shift = (raw_shift >= cipher_pkg::alphabet_size) ?
			raw_shift - cipher_pkg::alphabet_size : raw_shift; // Keys up to 31, one subtract is enough
		token.backward = snap_decode;
		token.slot = send_idx;
	end

	// Letter and key slots, indices wrap after the fifth load
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			letter_idx <= '0;
			key_idx <= '0;
			for (int i = 0; i < cipher_pkg::msg_len; i++)
			begin
				letters[i] <= '0;
				keys[i] <= '0;
			end
		end
		else
		begin
			if (letter_valid)
			begin
				letters[letter_idx] <= letter_in;
				letter_idx <= (letter_idx == last_slot) ? '0 : letter_idx + 1'b1;
			end
			if (key_valid)
			begin
				keys[key_idx] <= key_in;
				key_idx <= (key_idx == last_slot) ? '0 : key_idx + 1'b1;
			end
		end
	end

	// Snapshot payload
	always_ff @(posedge clock)
	begin
		if (state == load_idle && go)
		begin
			snap_letters <= letters;
			snap_keys <= keys;
			snap_method <= method;
			snap_decode <= decode;
		end
	end

	// Run FSM and credit count
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= load_idle;
			send_idx <= '0;
			credit <= link_pkg::credit_t'(depth); // Buffer starts empty
		end
		else
		begin
			credit <= credit - link_pkg::credit_t'(token_valid)
				+ link_pkg::credit_t'(credit_return);
			case (state)
				load_idle:
					if (go)
					begin
						send_idx <= '0;
						state <= load_send;
					end
				load_send:
					if (token_valid)
					begin
						if (send_idx == last_slot)
							state <= load_wait_done; // All five issued
						else
							send_idx <= send_idx + 1'b1;
					end
				default:
					if (done)
						state <= load_idle; // go ignored until here
			endcase
		end
	end

endmodule

// ==== src/shift_cipher_unit.sv ====
// Always ready; expects shifts already below 26, and codes outside 1..26 are written back unchanged
`timescale 1ns/100ps

module shift_cipher_unit (
	input  logic clock,
	input  logic resetn,
	input  link_pkg::letter_token_t head,
	input  logic not_empty,
	output logic pop,
	output cipher_pkg::message_t result,
	output logic done
);

	localparam cipher_pkg::slot_t last_slot = cipher_pkg::slot_t'(cipher_pkg::msg_len - 1);

	logic in_range;
	logic [5:0] wide; // One spare bit for wrap
	cipher_pkg::letter_t shifted;

	assign pop = not_empty; // Never stalls

	assign in_range = (head.letter >= cipher_pkg::letter_first)
		&& (head.letter <= cipher_pkg::letter_last);

	// Shift with wraparound inside a..z
	always_comb
	begin
		wide = {1'b0, head.letter};
		if (!head.backward)
		begin
			wide = {1'b0, head.letter} + {1'b0, head.shift};
			if (wide > {1'b0, cipher_pkg::letter_last})
				wide = wide - {1'b0, cipher_pkg::alphabet_size}; // Past z back to a
		end
		else if (head.letter <= head.shift)
			wide = {1'b0, head.letter} + {1'b0, cipher_pkg::alphabet_size}
				- {1'b0, head.shift}; // Before a back to z
		else
			wide = {1'b0, head.letter} - {1'b0, head.shift};
		shifted = in_range ? wide[4:0] : head.letter; // Non-letters pass through
	end

	// Result slots and done pulse
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			result <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= pop && (head.slot == last_slot); // Same edge as last write
			if (pop)
			begin
				case (head.slot)
					3'd0:    result.l0 <= shifted;
					3'd1:    result.l1 <= shifted;
					3'd2:    result.l2 <= shifted;
					3'd3:    result.l3 <= shifted;
					default: result.l4 <= shifted;
				endcase
			end
		end
	end

endmodule

// ==== src/token_fifo.sv ====
// No full check; the writer must hold credit, so depth must match the loader's credit (2..15)
`timescale 1ns/100ps

module token_fifo #(
	parameter int depth = 4
) (
	input  logic clock,
	input  logic resetn,
	input  logic token_valid,
	input  link_pkg::letter_token_t token,
	input  logic pop,
	output link_pkg::letter_token_t head,
	output logic not_empty,
	output logic credit_return
);

	localparam int ptr_w = $clog2(depth);

	typedef logic [ptr_w-1:0] ptr_t;

	localparam ptr_t last_ptr = ptr_t'(depth - 1);

	link_pkg::letter_token_t mem [depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	link_pkg::credit_t count; // Fill level
	logic do_pop;

	assign not_empty = (count != '0);
	assign do_pop = pop && not_empty;
	assign head = mem[rd_ptr]; // Head visible the cycle after its write
	assign credit_return = do_pop; // One credit back per pop

	// Storage
	always_ff @(posedge clock)
	begin
		if (token_valid)
			mem[wr_ptr] <= token;
	end

	// Pointers wrap at depth, not at a power of two
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (token_valid)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			count <= count + link_pkg::credit_t'(token_valid)
				- link_pkg::credit_t'(do_pop);
		end
	end

endmodule
